/* verilog/cpu_pkg.sv */
package cpu_pkg;

    localparam int word_size = 16;

    // opcodes
    localparam logic [3:0] op_bne   = 4'd0;
    localparam logic [3:0] op_beq   = 4'd1;
    localparam logic [3:0] op_bgz   = 4'd2;
    localparam logic [3:0] op_blz   = 4'd3;
    localparam logic [3:0] op_adi   = 4'd4;
    localparam logic [3:0] op_ori   = 4'd5;
    localparam logic [3:0] op_lhi   = 4'd6;
    localparam logic [3:0] op_lwd   = 4'd7;
    localparam logic [3:0] op_swd   = 4'd8;
    localparam logic [3:0] op_jmp   = 4'd9;
    localparam logic [3:0] op_jal   = 4'd10;
    localparam logic [3:0] op_rtype = 4'd15;

    // function codes of the r-type group
    localparam logic [5:0] fn_add = 6'd0;
    localparam logic [5:0] fn_sub = 6'd1;
    localparam logic [5:0] fn_and = 6'd2;
    localparam logic [5:0] fn_orr = 6'd3;
    localparam logic [5:0] fn_not = 6'd4;
    localparam logic [5:0] fn_tcp = 6'd5;
    localparam logic [5:0] fn_shl = 6'd6;
    localparam logic [5:0] fn_shr = 6'd7;
    localparam logic [5:0] fn_jpr = 6'd25;
    localparam logic [5:0] fn_jrl = 6'd26;
    localparam logic [5:0] fn_wwd = 6'd28;
    localparam logic [5:0] fn_hlt = 6'd29;

    // control vector, grouped by the stage that consumes the bits
    localparam int ctl_wwd       = 0;
    localparam int ctl_reg_write = 1;
    localparam int ctl_mem_to_reg = 2;
    localparam int ctl_mem_write = 3;
    localparam int ctl_mem_read  = 4;
    localparam int ctl_is_branch = 5;
    localparam int ctl_alu_src   = 6;
    localparam int ctl_is_alu    = 7;
    localparam int ctl_is_jump_r = 8;
    localparam int ctl_is_jump_i = 9;
    localparam int ctl_reg_dst   = 10;
    localparam int ctl_width     = 11;

    // alu operations
    localparam logic [3:0] alu_add = 4'd0;
    localparam logic [3:0] alu_sub = 4'd1;
    localparam logic [3:0] alu_and = 4'd2;
    localparam logic [3:0] alu_orr = 4'd3;
    localparam logic [3:0] alu_not = 4'd4;
    localparam logic [3:0] alu_tcp = 4'd5;
    localparam logic [3:0] alu_shl = 4'd6;
    localparam logic [3:0] alu_shr = 4'd7;
    localparam logic [3:0] alu_lhi = 4'd8;

    // jal and jrl write the return address here
    localparam logic [1:0] link_reg = 2'd2;

endpackage

/* verilog/control_unit.sv */
module control_unit (
    input  logic [cpu_pkg::word_size-1:0] id_instr,
    output logic [cpu_pkg::ctl_width-1:0] controls
);

    logic [3:0] opcode;
    logic [5:0] func;

    assign opcode = id_instr[15:12];
    assign func   = id_instr[5:0];

    always_comb begin
        controls = '0;
        case (opcode)
            cpu_pkg::op_bne, cpu_pkg::op_beq, cpu_pkg::op_bgz, cpu_pkg::op_blz: begin
                controls[cpu_pkg::ctl_is_branch] = 1'b1;
            end
            cpu_pkg::op_adi, cpu_pkg::op_ori, cpu_pkg::op_lhi: begin
                controls[cpu_pkg::ctl_reg_write] = 1'b1;
                controls[cpu_pkg::ctl_alu_src]   = 1'b1;
            end
            cpu_pkg::op_lwd: begin
                controls[cpu_pkg::ctl_reg_write]  = 1'b1;
                controls[cpu_pkg::ctl_mem_to_reg] = 1'b1;
                controls[cpu_pkg::ctl_mem_read]   = 1'b1;
                controls[cpu_pkg::ctl_alu_src]    = 1'b1;
            end
            cpu_pkg::op_swd: begin
                controls[cpu_pkg::ctl_mem_write] = 1'b1;
                controls[cpu_pkg::ctl_alu_src]   = 1'b1;
            end
            cpu_pkg::op_jmp: begin
                controls[cpu_pkg::ctl_is_jump_i] = 1'b1;
            end
            cpu_pkg::op_jal: begin
                controls[cpu_pkg::ctl_is_jump_i] = 1'b1;
                controls[cpu_pkg::ctl_reg_write] = 1'b1;
            end
            cpu_pkg::op_rtype: begin
                if (func <= cpu_pkg::fn_shr) begin
                    controls[cpu_pkg::ctl_reg_write] = 1'b1;
                    controls[cpu_pkg::ctl_is_alu]    = 1'b1;
                    controls[cpu_pkg::ctl_reg_dst]   = 1'b1;
                end else if (func == cpu_pkg::fn_jpr) begin
                    controls[cpu_pkg::ctl_is_jump_r] = 1'b1;
                end else if (func == cpu_pkg::fn_jrl) begin
                    controls[cpu_pkg::ctl_is_jump_r] = 1'b1;
                    controls[cpu_pkg::ctl_reg_write] = 1'b1;
                end else if (func == cpu_pkg::fn_wwd) begin
                    controls[cpu_pkg::ctl_wwd] = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

/* verilog/register_file.sv */
module register_file (
    input  logic                          Clk,
    input  logic                          rst_n,
    input  logic [1:0]                    rs,
    input  logic [1:0]                    rt,
    input  logic [1:0]                    wr_addr,
    input  logic [cpu_pkg::word_size-1:0] wr_data,
    input  logic                          wr_en,
    output logic [cpu_pkg::word_size-1:0] rs_data,
    output logic [cpu_pkg::word_size-1:0] rt_data
);

    logic [cpu_pkg::word_size-1:0] regs [4];

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // write-back lands in the same cycle it is read in decode
    assign rs_data = (wr_en && wr_addr == rs) ? wr_data : regs[rs];
    assign rt_data = (wr_en && wr_addr == rt) ? wr_data : regs[rt];

endmodule

/* verilog/alu.sv */
module alu (
    input  logic [cpu_pkg::word_size-1:0] a,
    input  logic [cpu_pkg::word_size-1:0] b,
    input  logic [3:0]                    opcode,
    input  logic [5:0]                    func,
    input  logic                          is_alu,
    input  logic                          is_branch,
    output logic [cpu_pkg::word_size-1:0] result,
    output logic                          bcond
);

    logic [3:0] op;

    always_comb begin
        op = cpu_pkg::alu_add;
        if (is_alu && opcode == cpu_pkg::op_rtype) begin
            case (func)
                cpu_pkg::fn_sub: op = cpu_pkg::alu_sub;
                cpu_pkg::fn_and: op = cpu_pkg::alu_and;
                cpu_pkg::fn_orr: op = cpu_pkg::alu_orr;
                cpu_pkg::fn_not: op = cpu_pkg::alu_not;
                cpu_pkg::fn_tcp: op = cpu_pkg::alu_tcp;
                cpu_pkg::fn_shl: op = cpu_pkg::alu_shl;
                cpu_pkg::fn_shr: op = cpu_pkg::alu_shr;
                default:         op = cpu_pkg::alu_add;
            endcase
        end else if (opcode == cpu_pkg::op_ori) begin
            op = cpu_pkg::alu_orr;
        end else if (opcode == cpu_pkg::op_lhi) begin
            op = cpu_pkg::alu_lhi;
        end
    end

    always_comb begin
        case (op)
            cpu_pkg::alu_sub: result = a - b;
            cpu_pkg::alu_and: result = a & b;
            cpu_pkg::alu_orr: result = a | b;
            cpu_pkg::alu_not: result = ~a;
            cpu_pkg::alu_tcp: result = ~a + 1'b1;
            cpu_pkg::alu_shl: result = {a[14:0], 1'b0};
            // arithmetic shift keeps the sign
            cpu_pkg::alu_shr: result = {a[15], a[15:1]};
            cpu_pkg::alu_lhi: result = {b[7:0], 8'h00};
            default:          result = a + b;
        endcase
    end

    always_comb begin
        bcond = 1'b0;
        if (is_branch) begin
            case (opcode)
                cpu_pkg::op_bne: bcond = (a != b);
                cpu_pkg::op_beq: bcond = (a == b);
                cpu_pkg::op_bgz: bcond = ($signed(a) > 0);
                cpu_pkg::op_blz: bcond = ($signed(a) < 0);
                default:         bcond = 1'b0;
            endcase
        end
    end

endmodule

/* verilog/hazard_unit.sv */
module hazard_unit (
    input  logic [1:0] ex_rs,
    input  logic [1:0] ex_rt,
    input  logic [1:0] mem_rd,
    input  logic       mem_reg_write,
    input  logic [1:0] wb_rd,
    input  logic       wb_reg_write,
    input  logic [1:0] id_rs,
    input  logic       id_use_rs,
    input  logic [1:0] id_rt,
    input  logic       id_use_rt,
    input  logic       ex_mem_read,
    input  logic [1:0] ex_rd,
    output logic [1:0] forward_a,
    output logic [1:0] forward_b,
    output logic       stall
);

    // 01 takes the memory-stage result, 10 the write-back value
    always_comb begin
        if (mem_reg_write && mem_rd == ex_rs) begin
            forward_a = 2'b01;
        end else if (wb_reg_write && wb_rd == ex_rs) begin
            forward_a = 2'b10;
        end else begin
            forward_a = 2'b00;
        end
    end

    always_comb begin
        if (mem_reg_write && mem_rd == ex_rt) begin
            forward_b = 2'b01;
        end else if (wb_reg_write && wb_rd == ex_rt) begin
            forward_b = 2'b10;
        end else begin
            forward_b = 2'b00;
        end
    end

    // load data only exists after the memory stage
    assign stall = ex_mem_read &&
                   ((id_use_rs && ex_rd == id_rs) || (id_use_rt && ex_rd == id_rt));

endmodule

/* verilog/datapath.sv */
module datapath (
    input  logic                          Clk,
    input  logic                          rst_n,
    input  logic [cpu_pkg::word_size-1:0] instr,
    input  logic [cpu_pkg::word_size-1:0] rdata_d,
    input  logic [cpu_pkg::ctl_width-1:0] controls,
    output logic                          read_i,
    output logic [cpu_pkg::word_size-1:0] address_i,
    output logic                          read_d,
    output logic                          write_d,
    output logic [cpu_pkg::word_size-1:0] address_d,
    output logic [cpu_pkg::word_size-1:0] wdata_d,
    output logic [cpu_pkg::word_size-1:0] id_instr,
    output logic                          is_halted,
    output logic [cpu_pkg::word_size-1:0] num_inst,
    output logic [cpu_pkg::word_size-1:0] output_port
);

    logic [cpu_pkg::word_size-1:0] pc, next_pc;

    logic [cpu_pkg::word_size-1:0] if_id_pc;
    logic                          if_id_bubble;

    logic [cpu_pkg::ctl_reg_dst-1:0]   id_ex_ctl;
    logic [cpu_pkg::word_size-1:0]     id_ex_pc, id_ex_rs_data, id_ex_rt_data, id_ex_imm;
    logic [1:0]                        id_ex_rs, id_ex_rt, id_ex_rd;
    logic [3:0]                        id_ex_opcode;
    logic [5:0]                        id_ex_func;
    logic                              id_ex_bubble;

    logic [cpu_pkg::ctl_is_branch-1:0] ex_mem_ctl;
    logic [cpu_pkg::word_size-1:0]     ex_mem_alu, ex_mem_rt_data;
    logic [1:0]                        ex_mem_rd;
    logic                              ex_mem_bubble, ex_mem_hlt;

    logic [cpu_pkg::ctl_mem_write-1:0] mem_wb_ctl;
    logic [cpu_pkg::word_size-1:0]     mem_wb_alu, mem_wb_rdata;
    logic [1:0]                        mem_wb_rd;
    logic                              mem_wb_bubble, mem_wb_hlt;

    logic [3:0]                    id_opcode;
    logic [5:0]                    id_func;
    logic [1:0]                    id_rs, id_rt, id_rd;
    logic [cpu_pkg::word_size-1:0] id_rs_data, id_rt_data, id_imm;
    logic                          id_use_rs, id_use_rt, id_jump, stall;

    logic [1:0]                    forward_a, forward_b;
    logic [cpu_pkg::word_size-1:0] ex_a_fwd, ex_b_fwd, alu_a, alu_b, alu_result, ex_target;
    logic                          bcond, ex_link, ex_flush, ex_hlt;
    logic [cpu_pkg::word_size-1:0] wb_data;

    assign read_i    = !is_halted;
    assign address_i = pc;
    assign read_d    = ex_mem_ctl[cpu_pkg::ctl_mem_read];
    assign write_d   = ex_mem_ctl[cpu_pkg::ctl_mem_write];
    assign address_d = ex_mem_alu;
    assign wdata_d   = ex_mem_rt_data;

    // decode
    assign id_opcode = id_instr[15:12];
    assign id_rs     = id_instr[11:10];
    assign id_rt     = id_instr[9:8];
    assign id_func   = id_instr[5:0];
    assign id_imm    = (id_opcode == cpu_pkg::op_ori) ? {8'h00, id_instr[7:0]}
                                                      : {{8{id_instr[7]}}, id_instr[7:0]};
    assign id_rd = (controls[cpu_pkg::ctl_reg_write] &&
                    (controls[cpu_pkg::ctl_is_jump_i] || controls[cpu_pkg::ctl_is_jump_r]))
                   ? cpu_pkg::link_reg
                   : (controls[cpu_pkg::ctl_reg_dst] ? id_instr[7:6] : id_rt);
    assign id_use_rs = !if_id_bubble && !(id_opcode inside
                       {cpu_pkg::op_jmp, cpu_pkg::op_jal, cpu_pkg::op_lhi});
    assign id_use_rt = !if_id_bubble &&
                       ((id_opcode == cpu_pkg::op_rtype && id_func <= cpu_pkg::fn_shr) ||
                        id_opcode == cpu_pkg::op_bne || id_opcode == cpu_pkg::op_beq ||
                        id_opcode == cpu_pkg::op_swd);
    assign id_jump = !if_id_bubble && controls[cpu_pkg::ctl_is_jump_i];

    // execute
    assign wb_data  = mem_wb_ctl[cpu_pkg::ctl_mem_to_reg] ? mem_wb_rdata : mem_wb_alu;
    assign ex_a_fwd = (forward_a == 2'b01) ? ex_mem_alu
                    : (forward_a == 2'b10) ? wb_data : id_ex_rs_data;
    assign ex_b_fwd = (forward_b == 2'b01) ? ex_mem_alu
                    : (forward_b == 2'b10) ? wb_data : id_ex_rt_data;
    assign ex_link  = id_ex_ctl[cpu_pkg::ctl_reg_write] &&
                      (id_ex_ctl[cpu_pkg::ctl_is_jump_i] || id_ex_ctl[cpu_pkg::ctl_is_jump_r]);
    // link value is pc+1 passed through the adder, wwd passes rs unchanged
    assign alu_a = ex_link ? id_ex_pc : ex_a_fwd;
    assign alu_b = (ex_link || id_ex_ctl[cpu_pkg::ctl_wwd]) ? '0
                 : (id_ex_ctl[cpu_pkg::ctl_alu_src] ? id_ex_imm : ex_b_fwd);
    assign ex_flush  = bcond || id_ex_ctl[cpu_pkg::ctl_is_jump_r];
    assign ex_target = id_ex_ctl[cpu_pkg::ctl_is_jump_r] ? ex_a_fwd : id_ex_pc + id_ex_imm;
    assign ex_hlt    = !id_ex_bubble && id_ex_opcode == cpu_pkg::op_rtype &&
                       id_ex_func == cpu_pkg::fn_hlt;

    always_comb begin
        if (ex_flush) begin
            next_pc = ex_target;
        end else if (stall) begin
            next_pc = pc;
        end else if (id_jump) begin
            next_pc = {if_id_pc[15:12], id_instr[11:0]};
        end else begin
            next_pc = pc + 1'b1;
        end
    end

    register_file u_register_file (
        .Clk(Clk), .rst_n(rst_n), .rs(id_rs), .rt(id_rt),
        .wr_addr(mem_wb_rd), .wr_data(wb_data), .wr_en(mem_wb_ctl[cpu_pkg::ctl_reg_write]),
        .rs_data(id_rs_data), .rt_data(id_rt_data)
    );

    alu u_alu (
        .a(alu_a), .b(alu_b), .opcode(id_ex_opcode), .func(id_ex_func),
        .is_alu(id_ex_ctl[cpu_pkg::ctl_is_alu]), .is_branch(id_ex_ctl[cpu_pkg::ctl_is_branch]),
        .result(alu_result), .bcond(bcond)
    );

    hazard_unit u_hazard_unit (
        .ex_rs(id_ex_rs), .ex_rt(id_ex_rt),
        .mem_rd(ex_mem_rd), .mem_reg_write(ex_mem_ctl[cpu_pkg::ctl_reg_write]),
        .wb_rd(mem_wb_rd), .wb_reg_write(mem_wb_ctl[cpu_pkg::ctl_reg_write]),
        .id_rs(id_rs), .id_use_rs(id_use_rs), .id_rt(id_rt), .id_use_rt(id_use_rt),
        .ex_mem_read(id_ex_ctl[cpu_pkg::ctl_mem_read]), .ex_rd(id_ex_rd),
        .forward_a(forward_a), .forward_b(forward_b), .stall(stall)
    );

    // bubble bits, control bits, pc and the retire side
    always_ff @(posedge Clk) begin
        if (!rst_n || mem_wb_hlt) begin
            pc            <= rst_n ? pc : '0;
            if_id_bubble  <= 1'b1;
            id_ex_bubble  <= 1'b1;
            ex_mem_bubble <= 1'b1;
            mem_wb_bubble <= 1'b1;
            id_ex_ctl     <= '0;
            ex_mem_ctl    <= '0;
            mem_wb_ctl    <= '0;
            ex_mem_hlt    <= 1'b0;
            mem_wb_hlt    <= 1'b0;
            is_halted     <= rst_n;
            num_inst      <= rst_n ? num_inst + 1'b1 : '0;
            output_port   <= '0;
        end else if (!is_halted) begin
            if (!mem_wb_bubble) begin
                num_inst <= num_inst + 1'b1;
                if (mem_wb_ctl[cpu_pkg::ctl_wwd]) begin
                    output_port <= wb_data;
                end
            end
            pc            <= next_pc;
            mem_wb_bubble <= ex_mem_bubble;
            mem_wb_ctl    <= ex_mem_ctl[cpu_pkg::ctl_mem_write-1:0];
            mem_wb_hlt    <= ex_mem_hlt;
            ex_mem_bubble <= id_ex_bubble;
            ex_mem_ctl    <= id_ex_ctl[cpu_pkg::ctl_is_branch-1:0];
            ex_mem_hlt    <= ex_hlt;
            if (stall || ex_flush || if_id_bubble) begin
                id_ex_bubble <= 1'b1;
                id_ex_ctl    <= '0;
            end else begin
                id_ex_bubble <= 1'b0;
                id_ex_ctl    <= controls[cpu_pkg::ctl_reg_dst-1:0];
            end
            if (ex_flush || id_jump) begin
                if_id_bubble <= 1'b1;
            end else if (!stall) begin
                if_id_bubble <= 1'b0;
            end
        end
    end

    // payload follows the bubble bits
    always_ff @(posedge Clk) begin
        if (!stall) begin
            id_instr <= instr;
            if_id_pc <= pc + 1'b1;
        end
        id_ex_pc       <= if_id_pc;
        id_ex_rs_data  <= id_rs_data;
        id_ex_rt_data  <= id_rt_data;
        id_ex_imm      <= id_imm;
        id_ex_rs       <= id_rs;
        id_ex_rt       <= id_rt;
        id_ex_rd       <= id_rd;
        id_ex_opcode   <= id_opcode;
        id_ex_func     <= id_func;
        ex_mem_alu     <= alu_result;
        ex_mem_rt_data <= ex_b_fwd;
        ex_mem_rd      <= id_ex_rd;
        mem_wb_alu     <= ex_mem_alu;
        mem_wb_rdata   <= rdata_d;
        mem_wb_rd      <= ex_mem_rd;
    end

    assert property (@(posedge Clk) disable iff (!rst_n) !(read_d && write_d))
        else $error("datapath: read_d and write_d high together");

    // one bubble always clears the load out of execute
    assert property (@(posedge Clk) disable iff (!rst_n) stall |=> !stall)
        else $error("datapath: load-use stall held for two cycles");

endmodule

/* verilog/cpu.sv */
module cpu (
    input  logic                          Clk,
    input  logic                          rst_n,
    input  logic [cpu_pkg::word_size-1:0] instr,
    input  logic [cpu_pkg::word_size-1:0] rdata_d,
    output logic                          read_i,
    output logic [cpu_pkg::word_size-1:0] address_i,
    output logic                          read_d,
    output logic                          write_d,
    output logic [cpu_pkg::word_size-1:0] address_d,
    output logic [cpu_pkg::word_size-1:0] wdata_d,
    output logic                          is_halted,
    output logic [cpu_pkg::word_size-1:0] num_inst,
    output logic [cpu_pkg::word_size-1:0] output_port
);

    logic [cpu_pkg::word_size-1:0] id_instr;
    logic [cpu_pkg::ctl_width-1:0] controls;

    control_unit u_control_unit (
        .id_instr(id_instr),
        .controls(controls)
    );

    datapath u_datapath (
        .Clk(Clk), .rst_n(rst_n), .instr(instr), .rdata_d(rdata_d), .controls(controls),
        .read_i(read_i), .address_i(address_i),
        .read_d(read_d), .write_d(write_d), .address_d(address_d), .wdata_d(wdata_d),
        .id_instr(id_instr), .is_halted(is_halted), .num_inst(num_inst),
        .output_port(output_port)
    );

endmodule

/* bench/tb_memory.sv */
module tb_memory (
    input  logic                          Clk,
    input  logic                          read_i,
    input  logic [cpu_pkg::word_size-1:0] address_i,
    output logic [cpu_pkg::word_size-1:0] instr,
    input  logic                          read_d,
    input  logic                          write_d,
    input  logic [cpu_pkg::word_size-1:0] address_d,
    input  logic [cpu_pkg::word_size-1:0] wdata_d,
    output logic [cpu_pkg::word_size-1:0] rdata_d
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [cpu_pkg::word_size-1:0] imem [256];
    logic [cpu_pkg::word_size-1:0] dmem [256];

    initial begin
        for (int i = 0; i < 256; i++) begin
            // unused program space halts the core
            imem[i] = {cpu_pkg::op_rtype, 6'd0, cpu_pkg::fn_hlt};
            dmem[i] = 16'(i) ^ 16'ha5c3;
        end
    end

    task automatic load_instr(input int addr, input logic [cpu_pkg::word_size-1:0] word);
        imem[addr[7:0]] = word;
    endtask

    // both ports answer in the same cycle
    assign instr   = read_i ? imem[address_i[7:0]] : '0;
    assign rdata_d = read_d ? dmem[address_d[7:0]] : '0;

    always @(posedge Clk) begin
        if (write_d) begin
            dmem[address_d[7:0]] <= wdata_d;
        end
    end

endmodule

/* bench/cpu_tb.sv */
module cpu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // the program needs about 60 cycles including reset, stalls and flushes
    localparam int timeout_cycles = 600;

    logic        Clk = 1'b0;
    logic        rst_n;
    logic [15:0] instr, rdata_d, address_i, address_d, wdata_d, num_inst, output_port;
    logic        read_i, read_d, write_d, is_halted;

    integer      seed;
    int          cycles = 0;
    int          prog_len = 0;
    int          exp_count = 0;
    int          n_wwd = 0;
    int          wwd_idx = 0;
    logic [15:0] exp_wwd [16];
    logic [15:0] exp_st_addr, exp_st_data, prev_port;
    logic        reset_window = 1'b0;
    logic        halt_seen = 1'b0;
    logic        store_seen = 1'b0;

    always #5 Clk = ~Clk;

    cpu u_dut (
        .Clk(Clk), .rst_n(rst_n), .instr(instr), .rdata_d(rdata_d),
        .read_i(read_i), .address_i(address_i), .read_d(read_d), .write_d(write_d),
        .address_d(address_d), .wdata_d(wdata_d), .is_halted(is_halted),
        .num_inst(num_inst), .output_port(output_port)
    );

    tb_memory u_mem (
        .Clk(Clk), .read_i(read_i), .address_i(address_i), .instr(instr),
        .read_d(read_d), .write_d(write_d), .address_d(address_d), .wdata_d(wdata_d),
        .rdata_d(rdata_d)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    function automatic logic [15:0] enc_i(input logic [3:0] op, input logic [1:0] rs,
                                          input logic [1:0] rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [15:0] enc_r(input logic [1:0] rs, input logic [1:0] rt,
                                          input logic [1:0] rd, input logic [5:0] fn);
        return {cpu_pkg::op_rtype, rs, rt, rd, fn};
    endfunction

    function automatic logic [7:0] small_imm();
        return 8'(($unsigned($random(seed)) % 30) + 1);
    endfunction

    task automatic emit(input logic [15:0] word, input bit on_path);
        u_mem.load_instr(prog_len, word);
        prog_len++;
        if (on_path) begin
            exp_count++;
        end
    endtask

    task automatic expect_wwd(input logic [15:0] value);
        exp_wwd[n_wwd] = value;
        n_wwd++;
    endtask

    task automatic build_program();
        logic [7:0]  a, b, c, e, f, g, h;
        logic [15:0] r1, r2, r3, r0;
        a = small_imm();
        b = small_imm();
        c = small_imm();
        e = small_imm();
        f = small_imm();
        g = small_imm();
        h = small_imm();
        // forwarding chain
        emit(enc_i(cpu_pkg::op_lhi, 2'd0, 2'd1, a), 1);
        emit(enc_i(cpu_pkg::op_ori, 2'd1, 2'd2, b), 1);
        emit(enc_i(cpu_pkg::op_adi, 2'd2, 2'd3, c), 1);
        emit(enc_r(2'd3, 2'd1, 2'd0, cpu_pkg::fn_add), 1);
        emit(enc_r(2'd0, 2'd0, 2'd0, cpu_pkg::fn_wwd), 1);
        emit(enc_r(2'd0, 2'd2, 2'd0, cpu_pkg::fn_sub), 1);
        emit(enc_r(2'd0, 2'd0, 2'd0, cpu_pkg::fn_wwd), 1);
        emit(enc_r(2'd0, 2'd1, 2'd3, cpu_pkg::fn_and), 1);
        emit(enc_r(2'd3, 2'd0, 2'd0, cpu_pkg::fn_wwd), 1);
        emit(enc_r(2'd3, 2'd3, 2'd2, cpu_pkg::fn_not), 1);
        emit(enc_r(2'd2, 2'd0, 2'd0, cpu_pkg::fn_wwd), 1);
        emit(enc_r(2'd2, 2'd2, 2'd1, cpu_pkg::fn_shl), 1);
        emit(enc_r(2'd1, 2'd0, 2'd0, cpu_pkg::fn_wwd), 1);
        r1 = 16'(a) << 8;
        r2 = r1 | {8'h00, b};
        r3 = r2 + {8'h00, c};
        r0 = r3 + r1;
        expect_wwd(r0);
        r0 = r0 - r2;
        expect_wwd(r0);
        r3 = r0 & r1;
        expect_wwd(r3);
        r2 = ~r3;
        expect_wwd(r2);
        r1 = r2 << 1;
        expect_wwd(r1);
        // store, then a load whose result is used at once
        emit(enc_i(cpu_pkg::op_lhi, 2'd0, 2'd0, 8'h00), 1);
        emit(enc_i(cpu_pkg::op_swd, 2'd0, 2'd1, e), 1);
        emit(enc_i(cpu_pkg::op_lwd, 2'd0, 2'd2, e), 1);
        emit(enc_i(cpu_pkg::op_adi, 2'd2, 2'd3, f), 1);
        emit(enc_r(2'd3, 2'd0, 2'd0, cpu_pkg::fn_wwd), 1);
        exp_st_addr = {8'h00, e};
        exp_st_data = r1;
        r3 = r1 + {8'h00, f};
        expect_wwd(r3);
        // r0 holds the poison value from here on
        emit(enc_i(cpu_pkg::op_lhi, 2'd0, 2'd0, 8'hde), 1);
        emit(enc_i(cpu_pkg::op_ori, 2'd0, 2'd0, 8'had), 1);
        emit(enc_i(cpu_pkg::op_beq, 2'd1, 2'd1, 8'd1), 1);
        emit(enc_r(2'd0, 2'd0, 2'd0, cpu_pkg::fn_wwd), 0);
        emit(enc_i(cpu_pkg::op_adi, 2'd3, 2'd3, g), 1);
        emit(enc_i(cpu_pkg::op_bne, 2'd1, 2'd1, 8'd1), 1);
        emit(enc_r(2'd3, 2'd0, 2'd0, cpu_pkg::fn_wwd), 1);
        r3 = r3 + {8'h00, g};
        expect_wwd(r3);
        emit({cpu_pkg::op_jmp, 12'd27}, 1);
        emit(enc_r(2'd0, 2'd0, 2'd0, cpu_pkg::fn_wwd), 0);
        emit({cpu_pkg::op_jal, 12'd31}, 1);
        // return point of the routine at 31
        emit(enc_r(2'd2, 2'd0, 2'd0, cpu_pkg::fn_wwd), 1);
        emit(enc_r(2'd0, 2'd0, 2'd0, cpu_pkg::fn_hlt), 1);
        emit(enc_r(2'd0, 2'd0, 2'd0, cpu_pkg::fn_wwd), 0);
        emit(enc_i(cpu_pkg::op_adi, 2'd3, 2'd1, h), 1);
        emit(enc_r(2'd1, 2'd0, 2'd0, cpu_pkg::fn_wwd), 1);
        emit(enc_r(2'd2, 2'd0, 2'd0, cpu_pkg::fn_jpr), 1);
        emit(enc_r(2'd0, 2'd0, 2'd0, cpu_pkg::fn_wwd), 0);
        emit(enc_r(2'd0, 2'd0, 2'd0, cpu_pkg::fn_wwd), 0);
        expect_wwd(r3 + {8'h00, h});
        // link value is the address after the jal
        expect_wwd(16'd28);
    endtask

    initial begin
        rst_n = 1'b0;
        seed = 19045;
        #1;
        build_program();
        repeat (8) @(posedge Clk);
        #1;
        rst_n = 1'b1;
        reset_window = 1'b1;
        @(posedge Clk);
        #1;
        reset_window = 1'b0;
        wait (is_halted);
        repeat (4) @(negedge Clk);
        #1;
        if (wwd_idx != n_wwd) begin
            abort_run($sformatf("FAILED wwd_count expected %0d actual %0d",
                                n_wwd, wwd_idx));
        end else if (!store_seen) begin
            abort_run("the store never reached the data port");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

    always @(posedge Clk) begin
        cycles = cycles + 1;
        if (cycles == timeout_cycles) begin
            abort_run("the core did not halt within the cycle limit");
        end
    end

    // outputs are stable at the falling edge
    always @(negedge Clk) begin
        if (rst_n && !is_halted && output_port != prev_port) begin
            wwd_idx <= wwd_idx + 1;
        end
        prev_port <= output_port;
        if (rst_n && write_d) begin
            store_seen <= 1'b1;
        end
        if (rst_n && is_halted) begin
            halt_seen <= 1'b1;
        end
    end

    assert property (@(negedge Clk) reset_window |-> {is_halted, write_d, read_d, read_i} == 4'b0001)
        else abort_run($sformatf("FAILED reset_status expected 0001 actual %b",
                                 {is_halted, write_d, read_d, read_i}));
    assert property (@(negedge Clk) reset_window |-> num_inst == 16'd0)
        else abort_run($sformatf("FAILED reset_num_inst expected 0 actual %0d", num_inst));
    assert property (@(negedge Clk) reset_window |-> output_port == 16'd0)
        else abort_run($sformatf("FAILED reset_output expected 0000 actual %h", output_port));
    assert property (@(negedge Clk) reset_window |-> address_i == 16'd0)
        else abort_run($sformatf("FAILED reset_fetch_addr expected 0000 actual %h",
                                 address_i));

    assert property (@(negedge Clk)
            (rst_n && !is_halted && output_port != prev_port) |->
            (wwd_idx < n_wwd && output_port == exp_wwd[wwd_idx]))
        else abort_run($sformatf("FAILED wwd_value expected %h actual %h",
                                 exp_wwd[$sampled(wwd_idx)], output_port));
    assert property (@(negedge Clk) rst_n |-> output_port != 16'hdead)
        else abort_run("a skipped instruction drove the poison value to the output port");

    assert property (@(negedge Clk) (rst_n && write_d) |-> address_d == exp_st_addr)
        else abort_run($sformatf("FAILED store_address expected %h actual %h",
                                 exp_st_addr, address_d));
    assert property (@(negedge Clk) (rst_n && write_d) |-> wdata_d == exp_st_data)
        else abort_run($sformatf("FAILED store_data expected %h actual %h",
                                 exp_st_data, wdata_d));

    assert property (@(negedge Clk) halt_seen |-> is_halted)
        else abort_run("FAILED halt_hold expected 1 actual 0");
    assert property (@(negedge Clk) halt_seen |-> !read_i)
        else abort_run("FAILED halt_read_i expected 0 actual 1");
    assert property (@(negedge Clk) halt_seen |-> output_port == 16'd0)
        else abort_run($sformatf("FAILED halt_output expected 0000 actual %h", output_port));
    assert property (@(negedge Clk) halt_seen |-> num_inst == 16'(exp_count))
        else abort_run($sformatf("FAILED num_inst expected %0d actual %0d",
                                 exp_count, num_inst));

endmodule

/* filelist.f */
verilog/cpu_pkg.sv
verilog/control_unit.sv
verilog/register_file.sv
verilog/alu.sv
verilog/hazard_unit.sv
verilog/datapath.sv
verilog/cpu.sv
bench/tb_memory.sv
bench/cpu_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb \
    -f filelist.f -o cpu_tb_sim
./obj_dir/cpu_tb_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
grep -q "TEST PASS" sim.log
